// ==== Bender.yml ====
package:
  name: mips_lite

sources:
  - include_dirs:
      - logic
    files:
      - logic/mips_pkg.sv
      - logic/data_bus_if.sv
      - logic/instr_ram.sv
      - logic/data_ram.sv
      - logic/register_file.sv
      - logic/mips_core.sv
      - logic/mips_top.sv
  - target: test
    files:
      - verification/mips_top_tb.sv

// ==== logic/data_bus_if.sv ====
`default_nettype none

// same-cycle data memory link between core and data RAM
interface data_bus_if;
    logic [31:0] addr;
    logic [3:0]  byte_en;
    logic [31:0] wdata;
    logic        write;
    // word at addr, valid in the same cycle
    logic [31:0] rdata;

    modport core (
        output addr,
        output byte_en,
        output wdata,
        output write,
        input  rdata
    );

    modport mem (
        input  addr,
        input  byte_en,
        input  wdata,
        input  write,
        output rdata
    );
endinterface

`default_nettype wire

// ==== logic/data_ram.sv ====
`default_nettype none

`include "mips_consts.svh"

module data_ram (
    input  logic        clk,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    data_bus_if.mem     bus,
    input  logic [31:0] debug_addr,
    output logic [31:0] debug_data
);

    localparam int AW = $clog2(`MIPS_DRAM_WORDS);
    localparam logic [31:0] DATA_END = `MIPS_DATA_BASE + `MIPS_DRAM_WORDS * 4;

    logic [31:0]   mem [0:`MIPS_DRAM_WORDS-1];
    logic [AW-1:0] bus_idx;

    // word offset from the start of the data region
    function automatic logic [AW-1:0] word_idx(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `MIPS_DATA_BASE;
        return offset[AW+1:2];
    endfunction

    assign bus_idx    = word_idx(bus.addr);
    assign bus.rdata  = mem[bus_idx];
    assign debug_data = mem[word_idx(debug_addr)];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[word_idx(load_addr)] <= load_data;
        end else if (bus.write) begin
            // only the enabled lanes change
            for (int b = 0; b < 4; b++) begin
                if (bus.byte_en[b]) begin
                    mem[bus_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    assert property (@(posedge clk)
        bus.write |-> (bus.addr >= `MIPS_DATA_BASE) && (bus.addr < DATA_END))
        else $error("store outside the data region at %h", bus.addr);

    assert property (@(posedge clk) load_en |-> !bus.write)
        else $error("data preload while the core is storing");

endmodule

`default_nettype wire

// ==== logic/instr_ram.sv ====
`default_nettype none

`include "mips_consts.svh"

module instr_ram (
    input  logic        clk,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    input  logic [31:0] fetch_addr,
    output logic [31:0] fetch_data
);

    localparam int AW = $clog2(`MIPS_IRAM_WORDS);

    logic [31:0] mem [0:`MIPS_IRAM_WORDS-1];

    // boot region and low addresses land on the same words
    function automatic logic [AW-1:0] word_idx(input logic [31:0] addr);
        logic [31:0] folded;
        folded = addr % `MIPS_BOOT_ADDR;
        return folded[AW+1:2];
    endfunction

    assign fetch_data = mem[word_idx(fetch_addr)];

    // program load, one word per cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[word_idx(load_addr)] <= load_data;
        end
    end

    // the pc only moves while the core runs, so a load must see a still fetch address
    assert property (@(posedge clk) load_en |-> $stable(fetch_addr))
        else $error("instruction load while the core is fetching");

endmodule

`default_nettype wire

// ==== logic/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// memory sizes and address map of the processor

// instruction RAM depth in 32-bit words
`define MIPS_IRAM_WORDS 4096

// data RAM depth in 32-bit words
`define MIPS_DRAM_WORDS 256

// reset vector, folded onto word 0 of the instruction RAM
`define MIPS_BOOT_ADDR 32'hBFC0_0000

// first byte address served by the data RAM
`define MIPS_DATA_BASE 32'h0000_0400

`endif

// ==== logic/mips_core.sv ====
`default_nettype none

`include "mips_consts.svh"

module mips_core (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    output logic [31:0] fetch_addr,
    input  logic [31:0] fetch_data,
    output logic [4:0]  rs_idx,
    output logic [4:0]  rt_idx,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    output logic        wr_en,
    output logic [4:0]  wr_idx,
    output logic [31:0] wr_data,
    data_bus_if.core    bus,
    output logic        active,
    output logic        halted
);

    import mips_pkg::*;

    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;
    instr_t      instr;
    logic [31:0] imm_sext;
    logic [31:0] mem_addr;
    logic        is_special;
    logic        is_addiu;
    logic        is_subu;
    logic        is_lb;
    logic        is_sb;
    logic        is_sh;
    logic        is_bne;
    logic        is_jr;
    logic        take;
    logic [31:0] take_target;
    logic        pend_valid;
    logic [31:0] pend_target;
    logic        halt_armed;
    logic [1:0]  load_lane;
    logic [7:0]  load_byte;

    assign fetch_addr = pc;
    assign instr      = fetch_data;
    assign pc_plus4   = pc + 32'd4;
    assign imm_sext   = {{16{instr.i.imm[15]}}, instr.i.imm};

    // decode
    assign is_special = instr.j.opcode == OP_SPECIAL;
    assign is_addiu   = instr.j.opcode == OP_ADDIU;
    assign is_lb      = instr.j.opcode == OP_LB;
    assign is_sb      = instr.j.opcode == OP_SB;
    assign is_sh      = instr.j.opcode == OP_SH;
    assign is_bne     = instr.j.opcode == OP_BNE;
    assign is_subu    = is_special && (instr.r.funct == FN_SUBU);
    assign is_jr      = is_special && (instr.r.funct == FN_JR);

    assign rs_idx = instr.r.rs;
    assign rt_idx = instr.i.rt;

    // addiu result and load/store address share one adder
    assign mem_addr = rs_data + imm_sext;

    // branch target is relative to the delay slot
    assign take = is_jr || (is_bne && (rs_data != rt_data));
    assign take_target = is_jr ? rs_data : pc_plus4 + {imm_sext[29:0], 2'b00};

    // a pending target replaces pc+4 once the delay slot retires
    assign next_pc    = pend_valid ? pend_target : pc_plus4;
    assign halt_armed = pend_valid && (pend_target == 32'd0);

    // load lanes count from the top of the word
    assign load_lane = ~mem_addr[1:0];
    assign load_byte = bus.rdata[{load_lane, 3'b000} +: 8];

    // register write back
    assign wr_en  = active && (is_addiu || is_subu || is_lb);
    assign wr_idx = is_subu ? instr.r.rd : instr.i.rt;

    always_comb begin
        if (is_subu) begin
            wr_data = rs_data - rt_data;
        end else if (is_lb) begin
            wr_data = {{24{load_byte[7]}}, load_byte};
        end else begin
            wr_data = mem_addr;
        end
    end

    // stores, data replicated into every lane it may hit
    assign bus.addr  = mem_addr;
    assign bus.write = active && (is_sb || is_sh);

    always_comb begin
        if (is_sh) begin
            bus.byte_en = mem_addr[1] ? 4'b1100 : 4'b0011;
            bus.wdata   = {2{rt_data[15:0]}};
        end else if (is_sb) begin
            bus.byte_en = 4'b0001 << mem_addr[1:0];
            bus.wdata   = {4{rt_data[7:0]}};
        end else begin
            bus.byte_en = 4'b0000;
            bus.wdata   = rt_data;
        end
    end

    // pc, delay slot and run state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= `MIPS_BOOT_ADDR;
            pend_valid <= 1'b0;
            active     <= 1'b0;
            halted     <= 1'b0;
        end else if (active) begin
            pc         <= next_pc;
            pend_valid <= take;
            // jump to 0 ends the run after its delay slot
            if (halt_armed) begin
                active <= 1'b0;
                halted <= 1'b1;
            end
        end else if (run && !halted) begin
            active <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            pend_target <= take_target;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) halted |-> !wr_en && !bus.write)
        else $error("write issued after halt");

endmodule

`default_nettype wire

// ==== logic/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_BNE     = 6'b000101,
        OP_ADDIU   = 6'b001001,
        OP_LB      = 6'b100000,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001
    } opcode_e;

    // function field of special opcode
    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_SUBU = 6'b100011
    } funct_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        funct_e      funct;
    } r_type_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_type_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [25:0] target;
    } j_type_t;

    // one fetched word, seen through each encoding
    typedef union packed {
        r_type_t r;
        i_type_t i;
        j_type_t j;
    } instr_t;

endpackage

`default_nettype wire

// ==== logic/mips_top.sv ====
`default_nettype none

module mips_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    input  logic        load_iram,
    input  logic        load_dram,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    input  logic [4:0]  debug_reg_idx,
    output logic [31:0] debug_reg_data,
    input  logic [31:0] debug_mem_addr,
    output logic [31:0] debug_mem_data,
    output logic        active,
    output logic        halted
);

    logic [31:0] fetch_addr;
    logic [31:0] fetch_data;
    logic [4:0]  rs_idx;
    logic [4:0]  rt_idx;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        rf_wr_en;
    logic [4:0]  rf_wr_idx;
    logic [31:0] rf_wr_data;

    data_bus_if dbus ();

    mips_core u_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .rs_idx     (rs_idx),
        .rt_idx     (rt_idx),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .wr_en      (rf_wr_en),
        .wr_idx     (rf_wr_idx),
        .wr_data    (rf_wr_data),
        .bus        (dbus.core),
        .active     (active),
        .halted     (halted)
    );

    instr_ram u_iram (
        .clk        (clk),
        .load_en    (load_iram),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

    data_ram u_dram (
        .clk        (clk),
        .load_en    (load_dram),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .bus        (dbus.mem),
        .debug_addr (debug_mem_addr),
        .debug_data (debug_mem_data)
    );

    register_file u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs_idx     (rs_idx),
        .rt_idx     (rt_idx),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .wr_en      (rf_wr_en),
        .wr_idx     (rf_wr_idx),
        .wr_data    (rf_wr_data),
        .debug_idx  (debug_reg_idx),
        .debug_data (debug_reg_data)
    );

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`default_nettype none

module register_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs_idx,
    input  logic [4:0]  rt_idx,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_idx,
    input  logic [31:0] wr_data,
    input  logic [4:0]  debug_idx,
    output logic [31:0] debug_data
);

    logic [31:0] regs [0:31];

    // r0 is never written, so it keeps its reset value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != 5'd0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs_data    = regs[rs_idx];
    assign rt_data    = regs[rt_idx];
    assign debug_data = regs[debug_idx];

    assert property (@(posedge clk) disable iff (!rst_n) regs[0] == 32'd0)
        else $error("r0 holds a non-zero value");

endmodule

`default_nettype wire

// ==== mips_lite.f ====
+incdir+logic
logic/mips_pkg.sv
logic/data_bus_if.sv
logic/instr_ram.sv
logic/data_ram.sv
logic/register_file.sv
logic/mips_core.sv
logic/mips_top.sv
verification/mips_top_tb.sv

// ==== verification/mips_stim.txt ====
# I: instruction word, byte address    D: data word, byte address
# R: register index, expected value    M: byte address, expected word
# program from the boot address: addiu, lb, subu, bne, sh
I 2402abcd 00000000
I 80030483 00000004
I 00432023 00000008
I 14800040 0000000c
I a4040484 00000010
# bne target: jr r0 with sb in its delay slot
I 00000008 00000110
I a0020480 00000114
# data preload
D 12345678 00000480
D 12345678 00000484
D 00000000 00000488
# registers after halt
R 00 00000000
R 01 00000000
R 02 ffffabcd
R 03 00000078
R 04 ffffab55
R 05 00000000
R 1f 00000000
# data words after halt
M 00000480 123456cd
M 00000484 1234ab55
M 00000488 00000000

// ==== verification/mips_top_tb.sv ====
`default_nettype none

module mips_top_tb;

    logic        clk;
    logic        rst_n;
    logic        run;
    logic        load_iram;
    logic        load_dram;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic [4:0]  debug_reg_idx;
    logic [31:0] debug_reg_data;
    logic [31:0] debug_mem_addr;
    logic [31:0] debug_mem_data;
    logic        active;
    logic        halted;

    // program, preload and expected results from the stim file
    logic [31:0] iram_addr_q[$];
    logic [31:0] iram_word_q[$];
    logic [31:0] dram_addr_q[$];
    logic [31:0] dram_word_q[$];
    logic [4:0]  reg_idx_q[$];
    logic [31:0] reg_val_q[$];
    logic [31:0] mem_addr_q[$];
    logic [31:0] mem_val_q[$];

    int errors      = 0;
    int checks      = 0;
    int cycles      = 0;
    int cycle_limit = 0;
    bit stim_ok     = 1'b0;

    mips_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .run            (run),
        .load_iram      (load_iram),
        .load_dram      (load_dram),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .debug_reg_idx  (debug_reg_idx),
        .debug_reg_data (debug_reg_data),
        .debug_mem_addr (debug_mem_addr),
        .debug_mem_data (debug_mem_data),
        .active         (active),
        .halted         (halted)
    );

    always #5 clk = ~clk;

    // watchdog over the whole run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic read_stim();
        int          fd;
        int          c;
        string       tag;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("verification/mips_stim.txt", "r");
        if (fd != 0) begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "I" || tag == "D" || tag == "R" || tag == "M") begin
                    void'($fscanf(fd, "%h %h", a, b));
                    if (tag == "I") begin
                        iram_word_q.push_back(a);
                        iram_addr_q.push_back(b);
                    end else if (tag == "D") begin
                        dram_word_q.push_back(a);
                        dram_addr_q.push_back(b);
                    end else if (tag == "R") begin
                        reg_idx_q.push_back(a[4:0]);
                        reg_val_q.push_back(b);
                    end else begin
                        mem_addr_q.push_back(a);
                        mem_val_q.push_back(b);
                    end
                end else begin
                    // skip the rest of a comment line
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end
            end
            $fclose(fd);
            stim_ok = (iram_word_q.size() > 0) && (reg_idx_q.size() + mem_addr_q.size() > 0);
        end
    endtask

    task automatic load_memories();
        foreach (iram_word_q[k]) begin
            @(posedge clk);
            load_iram <= 1'b1;
            load_addr <= iram_addr_q[k];
            load_data <= iram_word_q[k];
        end
        @(posedge clk);
        load_iram <= 1'b0;
        foreach (dram_word_q[k]) begin
            @(posedge clk);
            load_dram <= 1'b1;
            load_addr <= dram_addr_q[k];
            load_data <= dram_word_q[k];
        end
        @(posedge clk);
        load_dram <= 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] idx, output logic [31:0] value);
        @(posedge clk);
        debug_reg_idx <= idx;
        @(negedge clk);
        value = debug_reg_data;
    endtask

    task automatic read_mem(input logic [31:0] addr, output logic [31:0] value);
        @(posedge clk);
        debug_mem_addr <= addr;
        @(negedge clk);
        value = debug_mem_data;
    endtask

    task automatic check_results(input string when);
        logic [31:0] value;
        foreach (reg_idx_q[k]) begin
            read_reg(reg_idx_q[k], value);
            compare_value(value, reg_val_q[k], $sformatf("%s r%0d", when, reg_idx_q[k]));
        end
        foreach (mem_addr_q[k]) begin
            read_mem(mem_addr_q[k], value);
            compare_value(value, mem_val_q[k], $sformatf("%s mem %h", when, mem_addr_q[k]));
        end
        compare_value(halted, 1'b1, {when, " halted"});
        compare_value(active, 1'b0, {when, " active"});
    endtask

    initial begin
        logic [31:0] value;
        clk            = 1'b0;
        rst_n          = 1'b0;
        run            = 1'b0;
        load_iram      = 1'b0;
        load_dram      = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        debug_reg_idx  = '0;
        debug_mem_addr = '0;
        read_stim();
        if (!stim_ok) begin
            $display("the stim file could not be read or holds no program and no checks");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            cycle_limit = 16 * iram_word_q.size() + 100;
            repeat (8) @(posedge clk);
            rst_n <= 1'b1;
            @(negedge clk);
            compare_value(active, 1'b0, "active after reset");
            compare_value(halted, 1'b0, "halted after reset");
            for (int i = 0; i < 32; i++) begin
                read_reg(5'(i), value);
                compare_value(value, 32'd0, $sformatf("r%0d after reset", i));
            end
            load_memories();
            @(posedge clk);
            run <= 1'b1;
            // run is first sampled at the next edge, active follows it
            @(negedge clk);
            compare_value(active, 1'b0, "active before run is sampled");
            @(negedge clk);
            compare_value(active, 1'b1, "active one cycle after run");
            while (halted !== 1'b1) begin
                @(negedge clk);
            end
            compare_value(active, 1'b0, "active when halted rises");
            check_results("at halt");
            // state must hold while halted
            repeat (20) @(posedge clk);
            check_results("after 20 halted cycles");
            $display("checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
